// File: csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    localparam int CSR_WIDTH = 32;

    typedef logic [13:0] csr_addr_t;

    // Register addresses
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // Field positions, LSB of each field
    localparam int CRMD_PLV       = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF      = 5;
    localparam int CRMD_DATM      = 7;
    localparam int PRMD_PPLV      = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS       = 0;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;
    localparam int EENTRY_VA      = 6;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITV     = 2;
    localparam int TICLR_CLR      = 0;

    // Implemented bits of the mode registers
    localparam logic [CSR_WIDTH-1:0] CRMD_MASK =
        (32'h3 << CRMD_PLV) | (32'h1 << CRMD_IE) | (32'h1 << CRMD_DA) |
        (32'h1 << CRMD_PG) | (32'h3 << CRMD_DATF) | (32'h3 << CRMD_DATM);
    localparam logic [CSR_WIDTH-1:0] PRMD_MASK =
        (32'h3 << PRMD_PPLV) | (32'h1 << PRMD_PIE);
    localparam logic [CSR_WIDTH-1:0] EENTRY_MASK = {CSR_WIDTH{1'b1}} << EENTRY_VA;

    // Interrupt lines in ESTAT.IS
    localparam int INT_COUNT     = 13;
    localparam int HW_INT_COUNT  = 8;
    localparam int HW_INT_LSB    = 2;
    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_INT_BIT   = 12;
    // Bit 10 has no source
    localparam logic [INT_COUNT-1:0] ECFG_LIE_MASK = 13'h1bff;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam logic [ECODE_W-1:0]    ECODE_ADE     = 6'h08;
    localparam logic [ECODE_W-1:0]    ECODE_ALE     = 6'h09;
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000;

    localparam logic [CSR_WIDTH-1:0] TIMER_IDLE = {CSR_WIDTH{1'b1}};

endpackage

`default_nettype wire

// File: csr_bus_pkg.sv
`default_nettype none

package csr_bus_pkg;

    import csr_map_pkg::*;

    // Software write strobe from the instruction port
    typedef struct packed {
        logic                 we;
        csr_addr_t            addr;
        logic [CSR_WIDTH-1:0] mask;
        logic [CSR_WIDTH-1:0] data;
    } csr_write_t;

    // Event retiring in writeback
    typedef struct packed {
        logic                  ex;
        logic                  ertn;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [CSR_WIDTH-1:0]  pc;
        logic [CSR_WIDTH-1:0]  vaddr;
    } exc_event_t;

    function automatic logic csr_hit(csr_write_t wr, csr_addr_t addr);
        return wr.we && (wr.addr == addr);
    endfunction

    // Masked-off bits keep the old value
    function automatic logic [CSR_WIDTH-1:0] csr_merge(csr_write_t wr,
                                                       logic [CSR_WIDTH-1:0] old);
        return (wr.data & wr.mask) | (old & ~wr.mask);
    endfunction

endpackage

`default_nettype wire

// File: csr_mode_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_mode_regs
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  csr_addr_t            raddr,
    input  csr_write_t           csr_wr,
    input  exc_event_t           exc,
    output logic [CSR_WIDTH-1:0] rdata,
    output logic [CSR_WIDTH-1:0] ex_entry,
    output logic                 crmd_ie
);

    logic [CSR_WIDTH-1:0]  crmd;
    logic [CSR_WIDTH-1:0]  prmd;
    logic [CSR_WIDTH-1:0]  era;
    logic [CSR_WIDTH-1:0]  badv;
    logic [CSR_WIDTH-1:0]  eentry;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [ESUBCODE_W-1:0] estat_esubcode;
    logic [CSR_WIDTH-1:0]  estat_codes;
    logic                  addr_err;

    // Entry clears PLV and IE, ertn restores them from PRMD
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= '0;
        end else if (exc.ex) begin
            crmd[CRMD_PLV +: 2] <= 2'b00;
            crmd[CRMD_IE]       <= 1'b0;
        end else if (exc.ertn) begin
            crmd[CRMD_PLV +: 2] <= prmd[PRMD_PPLV +: 2];
            crmd[CRMD_IE]       <= prmd[PRMD_PIE];
        end else if (csr_hit(csr_wr, CSR_CRMD)) begin
            crmd <= csr_merge(csr_wr, crmd) & CRMD_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            prmd[PRMD_PPLV +: 2] <= crmd[CRMD_PLV +: 2];
            prmd[PRMD_PIE]       <= crmd[CRMD_IE];
        end else if (csr_hit(csr_wr, CSR_PRMD)) begin
            prmd <= csr_merge(csr_wr, prmd) & PRMD_MASK;
        end
    end

    assign addr_err = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            era            <= exc.pc;
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
        end else if (csr_hit(csr_wr, CSR_ERA)) begin
            era <= csr_merge(csr_wr, era);
        end

        // Fetch address errors report the pc itself
        if (exc.ex && addr_err) begin
            if (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
                badv <= exc.pc;
            else
                badv <= exc.vaddr;
        end else if (csr_hit(csr_wr, CSR_BADV)) begin
            badv <= csr_merge(csr_wr, badv);
        end

        if (csr_hit(csr_wr, CSR_EENTRY))
            eentry <= csr_merge(csr_wr, eentry) & EENTRY_MASK;
    end

    always_comb begin
        estat_codes = '0;
        estat_codes[ESTAT_ECODE +: ECODE_W]       = estat_ecode;
        estat_codes[ESTAT_ESUBCODE +: ESUBCODE_W] = estat_esubcode;
    end

    always_comb begin
        case (raddr)
            CSR_CRMD:   rdata = crmd;
            CSR_PRMD:   rdata = prmd;
            CSR_ESTAT:  rdata = estat_codes;
            CSR_ERA:    rdata = era;
            CSR_BADV:   rdata = badv;
            CSR_EENTRY: rdata = eentry;
            default:    rdata = '0;
        endcase
    end

    assign ex_entry = eentry;
    assign crmd_ie  = crmd[CRMD_IE];

    // Writeback never retires an exception and an ertn together
    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc.ex && exc.ertn));

endmodule

`default_nettype wire

// File: csr_int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_int_ctrl
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  csr_addr_t               raddr,
    input  csr_write_t              csr_wr,
    input  logic [HW_INT_COUNT-1:0] hw_int,
    input  logic                    ipi_int,
    input  logic                    timer_int,
    input  logic                    crmd_ie,
    output logic [CSR_WIDTH-1:0]    rdata,
    output logic                    has_int
);

    logic [INT_COUNT-1:0]    ecfg_lie;
    logic [CSR_WIDTH-1:0]    ecfg_next;
    logic [CSR_WIDTH-1:0]    estat_next;
    logic [1:0]              swi;
    logic [HW_INT_COUNT-1:0] hw_q;
    logic                    ipi_q;
    logic [INT_COUNT-1:0]    is_vec;

    assign ecfg_next  = csr_merge(csr_wr, CSR_WIDTH'(ecfg_lie));
    assign estat_next = csr_merge(csr_wr, CSR_WIDTH'(is_vec) << ESTAT_IS);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            swi      <= 2'b00;
        end else begin
            if (csr_hit(csr_wr, CSR_ECFG))
                ecfg_lie <= ecfg_next[INT_COUNT-1:0] & ECFG_LIE_MASK;
            // Only the two software interrupt bits are writable
            if (csr_hit(csr_wr, CSR_ESTAT))
                swi <= estat_next[ESTAT_IS +: 2];
        end
    end

    // External lines sampled every cycle
    always_ff @(posedge clk) begin
        hw_q  <= hw_int;
        ipi_q <= ipi_int;
    end

    always_comb begin
        is_vec = '0;
        is_vec[1:0] = swi;
        is_vec[HW_INT_LSB +: HW_INT_COUNT] = hw_q;
        is_vec[TIMER_INT_BIT] = timer_int;
        is_vec[IPI_INT_BIT]   = ipi_q;
    end

    assign has_int = (|(is_vec & ecfg_lie)) && crmd_ie;

    always_comb begin
        case (raddr)
            CSR_ECFG:  rdata = CSR_WIDTH'(ecfg_lie);
            CSR_ESTAT: rdata = CSR_WIDTH'(is_vec) << ESTAT_IS;
            default:   rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  csr_addr_t            raddr,
    input  csr_write_t           csr_wr,
    output logic [CSR_WIDTH-1:0] rdata,
    output logic                 timer_int
);

    localparam int INITV_W = CSR_WIDTH - TCFG_INITV;

    logic                 tcfg_en;
    logic                 tcfg_periodic;
    logic [INITV_W-1:0]   tcfg_initv;
    logic [CSR_WIDTH-1:0] tcfg_value;
    logic [CSR_WIDTH-1:0] tcfg_next;
    logic                 tcfg_wr;
    logic                 ticlr_clr;
    logic [CSR_WIDTH-1:0] timer_cnt;
    logic                 cnt_zero;

    always_comb begin
        tcfg_value = '0;
        tcfg_value[TCFG_EN]       = tcfg_en;
        tcfg_value[TCFG_PERIODIC] = tcfg_periodic;
        tcfg_value[TCFG_INITV +: INITV_W] = tcfg_initv;
    end

    assign tcfg_wr   = csr_hit(csr_wr, CSR_TCFG);
    assign tcfg_next = csr_merge(csr_wr, tcfg_value);
    assign ticlr_clr = csr_hit(csr_wr, CSR_TICLR) && csr_wr.mask[TICLR_CLR]
                       && csr_wr.data[TICLR_CLR];
    assign cnt_zero  = (timer_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= tcfg_next[TCFG_EN];
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initv    <= tcfg_next[TCFG_INITV +: INITV_W];
        end
    end

    // Load on enable, then count down to idle or reload when periodic
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[TCFG_EN]) begin
            timer_cnt <= {tcfg_next[TCFG_INITV +: INITV_W], {TCFG_INITV{1'b0}}};
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (cnt_zero && tcfg_periodic)
                timer_cnt <= {tcfg_initv, {TCFG_INITV{1'b0}}};
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    // Setting at zero wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (cnt_zero)
            timer_int <= 1'b1;
        else if (ticlr_clr)
            timer_int <= 1'b0;
    end

    always_comb begin
        case (raddr)
            CSR_TCFG: rdata = tcfg_value;
            CSR_TVAL: rdata = timer_cnt;
            default:  rdata = '0;
        endcase
    end

    a_cnt_hold: assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !tcfg_wr) |=> $stable(timer_cnt));

endmodule

`default_nettype wire

// File: csr_scratch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_regs
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
#(
    parameter logic [CSR_WIDTH-1:0] CORE_ID    = '0,
    parameter int                   SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_addr_t            raddr,
    input  csr_write_t           csr_wr,
    output logic [CSR_WIDTH-1:0] rdata
);

    logic [CSR_WIDTH-1:0] save_q [SAVE_COUNT];
    logic [CSR_WIDTH-1:0] tid;

    // SAVE registers sit at consecutive addresses
    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_hit(csr_wr, csr_addr_t'(CSR_SAVE0 + i)))
                save_q[i] <= csr_merge(csr_wr, save_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tid <= CORE_ID;
        else if (csr_hit(csr_wr, CSR_TID))
            tid <= csr_merge(csr_wr, tid);
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (raddr == csr_addr_t'(CSR_SAVE0 + i))
                rdata = save_q[i];
        end
        if (raddr == CSR_TID)
            rdata = tid;
    end

endmodule

`default_nettype wire

// File: csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
#(
    parameter logic [CSR_WIDTH-1:0] CORE_ID    = '0,
    parameter int                   SAVE_COUNT = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_addr_t               raddr,
    input  csr_write_t              csr_wr,
    input  exc_event_t              exc,
    input  logic [HW_INT_COUNT-1:0] hw_int,
    input  logic                    ipi_int,
    output logic [CSR_WIDTH-1:0]    rdata,
    output logic [CSR_WIDTH-1:0]    ex_entry,
    output logic                    has_int
);

    logic [CSR_WIDTH-1:0] mode_rdata;
    logic [CSR_WIDTH-1:0] int_rdata;
    logic [CSR_WIDTH-1:0] timer_rdata;
    logic [CSR_WIDTH-1:0] scratch_rdata;
    logic                 crmd_ie;
    logic                 timer_int;

    csr_mode_regs u_mode_regs (
        .clk      (clk),
        .reset    (reset),
        .raddr    (raddr),
        .csr_wr   (csr_wr),
        .exc      (exc),
        .rdata    (mode_rdata),
        .ex_entry (ex_entry),
        .crmd_ie  (crmd_ie)
    );

    csr_int_ctrl u_int_ctrl (
        .clk       (clk),
        .reset     (reset),
        .raddr     (raddr),
        .csr_wr    (csr_wr),
        .hw_int    (hw_int),
        .ipi_int   (ipi_int),
        .timer_int (timer_int),
        .crmd_ie   (crmd_ie),
        .rdata     (int_rdata),
        .has_int   (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .raddr     (raddr),
        .csr_wr    (csr_wr),
        .rdata     (timer_rdata),
        .timer_int (timer_int)
    );

    csr_scratch_regs #(
        .CORE_ID    (CORE_ID),
        .SAVE_COUNT (SAVE_COUNT)
    ) u_scratch_regs (
        .clk    (clk),
        .reset  (reset),
        .raddr  (raddr),
        .csr_wr (csr_wr),
        .rdata  (scratch_rdata)
    );

    // Blocks return zero off their own addresses, ESTAT comes from two of them
    assign rdata = mode_rdata | int_rdata | timer_rdata | scratch_rdata;

endmodule

`default_nettype wire

// File: tb_csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_regfile
    import csr_map_pkg::*;
    import csr_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DELAY  = 1;
    // Sample two ns before the next rising edge
    localparam int SAMPLE_DELAY = CLK_PERIOD - DRIVE_DELAY - 2;
    localparam int RESET_CYCLES = 2;
    localparam int SLACK_CYCLES = 50;

    logic                    clk;
    logic                    reset;
    csr_addr_t               raddr;
    csr_write_t              csr_wr;
    exc_event_t              exc;
    logic [HW_INT_COUNT-1:0] hw_int;
    logic                    ipi_int;
    logic [CSR_WIDTH-1:0]    rdata;
    logic [CSR_WIDTH-1:0]    ex_entry;
    logic                    has_int;

    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    bit limit_ready = 1'b0;

    // EENTRY as software last wrote it
    logic [CSR_WIDTH-1:0] expected_entry;

    csr_regfile #(
        .CORE_ID    (32'h0000_0001),
        .SAVE_COUNT (4)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .raddr    (raddr),
        .csr_wr   (csr_wr),
        .exc      (exc),
        .hw_int   (hw_int),
        .ipi_int  (ipi_int),
        .rdata    (rdata),
        .ex_entry (ex_entry),
        .has_int  (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (limit_ready && cycle_count > cycle_limit);
        $display("Timeout: run passed %0d cycles, %0d errors so far", cycle_limit, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Strobes last for one cycle only
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        csr_wr.we = 1'b0;
        exc.ex    = 1'b0;
        exc.ertn  = 1'b0;
    endtask

    task automatic write_csr(input logic [31:0] addr, input logic [31:0] mask,
                             input logic [31:0] data);
        csr_wr.we   = 1'b1;
        csr_wr.addr = csr_addr_t'(addr);
        csr_wr.mask = mask;
        csr_wr.data = data;
        // Entry address keeps VA only, bits 5..0 read as zero
        if (csr_addr_t'(addr) == CSR_EENTRY)
            expected_entry = ((data & mask) | (expected_entry & ~mask)) & ~32'h0000_003f;
        next_cycle();
    endtask

    task automatic read_and_check(input logic [31:0] addr, input logic [31:0] expected);
        raddr = csr_addr_t'(addr);
        #SAMPLE_DELAY;
        check_value($sformatf("rdata@%h", addr[13:0]), expected, rdata);
        next_cycle();
    endtask

    task automatic raise_exception(input logic [31:0] ecode, input logic [31:0] esubcode,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        check_value("ex_entry", expected_entry, ex_entry);
        exc.ex       = 1'b1;
        exc.ecode    = ecode[ECODE_W-1:0];
        exc.esubcode = esubcode[ESUBCODE_W-1:0];
        exc.pc       = pc;
        exc.vaddr    = vaddr;
        next_cycle();
    endtask

    task automatic return_from_exception();
        exc.ertn = 1'b1;
        next_cycle();
    endtask

    task automatic set_int_lines(input logic [31:0] hw, input logic [31:0] ipi);
        hw_int  = hw[HW_INT_COUNT-1:0];
        ipi_int = ipi[0];
        next_cycle();
    endtask

    task automatic check_has_int(input logic [31:0] expected);
        #SAMPLE_DELAY;
        check_value("has_int", expected, {31'b0, has_int});
        next_cycle();
    endtask

    task automatic report_bad_line(input int index, input string text);
        $display("Trace line %0d could not be parsed: %s", index, text);
        errors++;
    endtask

    initial begin
        string       trace[$];
        string       line;
        string       op;
        int          fd;
        int          count;
        int          budget;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;

        reset   = 1'b1;
        raddr   = '0;
        csr_wr  = '0;
        exc     = '0;
        hw_int  = '0;
        ipi_int = 1'b0;
        budget  = RESET_CYCLES + 1;

        // Load the trace first so the cycle limit is known
        fd = $fopen("csr_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file csr_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && $sscanf(line, "%s", op) == 1
                    && op.getc(0) != "#") begin
                    trace.push_back(line);
                    if (op == "N" && $sscanf(line, "%s %d", op, count) == 2)
                        budget += count;
                    else
                        budget += 1;
                end
            end
            $fclose(fd);
        end
        cycle_limit = budget + SLACK_CYCLES;
        limit_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        foreach (trace[i]) begin
            line = trace[i];
            void'($sscanf(line, "%s", op));
            if (op == "W" && $sscanf(line, "%s %h %h %h", op, f1, f2, f3) == 4)
                write_csr(f1, f2, f3);
            else if (op == "R" && $sscanf(line, "%s %h %h", op, f1, f2) == 3)
                read_and_check(f1, f2);
            else if (op == "E" && $sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4) == 5)
                raise_exception(f1, f2, f3, f4);
            else if (op == "X")
                return_from_exception();
            else if (op == "I" && $sscanf(line, "%s %h %h", op, f1, f2) == 3)
                set_int_lines(f1, f2);
            else if (op == "N" && $sscanf(line, "%s %d", op, count) == 2)
                repeat (count) next_cycle();
            else if (op == "H" && $sscanf(line, "%s %h", op, f1) == 2)
                check_has_int(f1);
            else
                report_bad_line(i, line);
        end
        next_cycle();

        $display("Trace lines: %0d, errors: %0d", trace.size(), errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_trace.txt
# W addr mask data | R addr expected | E ecode esubcode pc vaddr | X (ertn)
# I hw_int ipi | N idle_cycles (decimal) | H has_int ; other fields hex
# reset values and masked writes
R 040 00000001
R 000 00000000
H 0
W 030 ffffffff 12345678
W 030 0000ff00 ffffabff
W 033 ffffffff a5a5a5a5
R 030 1234ab78
R 033 a5a5a5a5
W 00c ffffffff 1c00003f
R 00c 1c000000
W 00c 0000ff00 ffff12ff
R 00c 1c001200
W 004 ffffffff ffffffff
R 004 00001bff
W 004 00000fff 00000004
R 004 00001004
# exception entry, ADE with ADEF then ALE
W 001 ffffffff 00000000
W 000 00000007 00000007
R 000 00000007
H 0
E 08 000 1c000100 deadbeef
R 000 00000000
R 001 00000007
R 006 1c000100
R 007 1c000100
R 005 00080000
W 000 00000007 00000005
E 09 000 1c000200 00001234
R 007 00001234
R 006 1c000200
R 005 00090000
R 001 00000005
R 000 00000000
# ertn
X
R 000 00000005
H 0
# interrupts
I 01 0
H 1
R 005 00090004
W 000 00000004 00000000
R 000 00000001
H 0
I 00 0
R 005 00090000
# one-shot timer, INITV 4
W 041 ffffffff 00000011
R 042 00000010
N 5
R 042 0000000a
N 12
R 042 ffffffff
R 005 00090800
W 044 00000001 00000001
R 005 00090000
# periodic timer
W 041 ffffffff 00000013
R 041 00000013
N 19
R 042 0000000d
R 005 00090800
W 041 ffffffff 00000000

// File: all.f
csr_map_pkg.sv
csr_bus_pkg.sv
csr_mode_regs.sv
csr_int_ctrl.sv
csr_timer.sv
csr_scratch_regs.sv
csr_regfile.sv
tb_csr_regfile.sv
